// File: compile.f
common/burst_pkg.sv
src/burst_ctrl.sv
split/burst_split.sv
src/strobe_gen.sv
src/burst_align_top.sv
tests/burst_align_assertions.sv
tests/tb_burst_align.sv

// File: run.sh
#!/usr/bin/env bash
# builds the realignment path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_burst_align \
    --Mdir obj_dir \
    -o tb_burst_align \
    -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/tb_burst_align
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished without errors"
exit 0

// File: tests/tb_burst_align.sv
// testbench for the write-data realignment path

module tb_burst_align;

    import burst_pkg::*;

    localparam int n_rows = 13;

    typedef struct packed {
        logic [2:0] offset;
        logic [8:0] words;
        logic [1:0] stall;
        logic       reuse;
    } row_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } beat_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic [2:0]  offset;
    logic [7:0]  len;
    logic [31:0] data_in;
    logic        ready_out;
    logic        ready_in;
    logic        busy;
    logic [31:0] out_data;
    logic [3:0]  out_strb;
    logic        out_last;
    logic        out_valid;

    row_t        bursts [n_rows];
    beat_t       exp_q[$];
    logic [31:0] words[$];
    int          widx;
    int          last_count;
    logic        consume_pend;
    logic        cmd_start;
    logic [2:0]  cmd_offset;
    logic [7:0]  cmd_len;
    logic [1:0]  stall_sel;

    burst_align_top #(.data_w(32)) i_dut (.*);

    always #50 clk = ~clk;

    task automatic stop_failed();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_error(string what);
        $display("%s", what);
        stop_failed();
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        $display("MISMATCH %s expected %h got %h", name, exp, got);
        stop_failed();
    endtask

    // offset, words, stall selector, reuse the previous burst's words
    task automatic fill_table();
        bursts[0]  = '{3'd0, 9'd4,   2'd0, 1'b0};
        bursts[1]  = '{3'd1, 9'd5,   2'd0, 1'b0};
        bursts[2]  = '{3'd2, 9'd3,   2'd0, 1'b0};
        bursts[3]  = '{3'd3, 9'd6,   2'd0, 1'b0};
        bursts[4]  = '{3'd1, 9'd1,   2'd0, 1'b0};
        bursts[5]  = '{3'd3, 9'd1,   2'd0, 1'b0};
        bursts[6]  = '{3'd2, 9'd8,   2'd0, 1'b0};
        bursts[7]  = '{3'd2, 9'd8,   2'd2, 1'b1};
        bursts[8]  = '{3'd0, 9'd6,   2'd1, 1'b0};
        bursts[9]  = '{3'd3, 9'd16,  2'd1, 1'b0};
        bursts[10] = '{3'd1, 9'd2,   2'd3, 1'b0};
        bursts[11] = '{3'd0, 9'd1,   2'd0, 1'b0};
        bursts[12] = '{3'd2, 9'd256, 2'd1, 1'b0};
    endtask

    // lane j of beat k holds stream byte k*4 + j - offset when that byte exists
    task automatic push_expected(int off, int n);
        beat_t e;
        int    nbeats;
        int    s;
        nbeats = (off != 0) ? n + 1 : n;
        for (int k = 0; k < nbeats; k++) begin
            e = '0;
            for (int j = 0; j < 4; j++) begin
                s = k * 4 + j - off;
                if (s >= 0 && s < n * 4) begin
                    e.strb[j] = 1'b1;
                    e.data[j*8 +: 8] = words[s / 4][(s % 4) * 8 +: 8];
                end
            end
            e.last = (k == nbeats - 1);
            exp_q.push_back(e);
        end
    endtask

    task automatic check_beat();
        beat_t       e;
        logic [31:0] mask;
        assert (exp_q.size() > 0)
            else report_error("an output beat was delivered while none was expected");
        e = exp_q.pop_front();
        for (int j = 0; j < 4; j++) begin
            mask[j*8 +: 8] = {8{e.strb[j]}};
        end
        assert (out_strb == e.strb) else report_mismatch("out_strb", 32'(e.strb), 32'(out_strb));
        assert ((out_data & mask) == e.data) else report_mismatch("out_data", e.data, out_data & mask);
        assert (out_last == e.last) else report_mismatch("out_last", 32'(e.last), 32'(out_last));
    endtask

    // one clock cycle, inputs change on the falling edge only
    task automatic step();
        @(negedge clk);
        if (consume_pend) begin
            widx++;
        end
        start     = cmd_start;
        offset    = cmd_offset;
        len       = cmd_len;
        data_in   = (widx < words.size()) ? words[widx] : 32'h0;
        ready_out = (($urandom % 4) >= stall_sel);
        // the beat on the outputs is delivered at the coming rising edge
        if (out_valid && ready_out) begin
            check_beat();
        end
        // a last flag on a bubble is counted as well
        if (out_last && ready_out) begin
            last_count++;
        end
        #1;
        consume_pend = ready_in;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        do begin
            step();
            cycles++;
        end while (busy && cycles < 5000);
        assert (!busy) else report_error("timed out waiting for busy to go low");
    endtask

    initial begin
        void'($urandom(69465));
        rst = 1'b1;
        start = 1'b0;
        offset = '0;
        len = '0;
        data_in = '0;
        ready_out = 1'b0;
        cmd_start = 1'b0;
        cmd_offset = '0;
        cmd_len = '0;
        stall_sel = '0;
        consume_pend = 1'b0;
        widx = 0;
        last_count = 0;
        fill_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        ready_out = 1'b1;
        #1;
        assert (!out_valid) else report_mismatch("out_valid", 32'h0, 32'(out_valid));
        assert (!out_last) else report_mismatch("out_last", 32'h0, 32'(out_last));
        assert (out_strb == '0) else report_mismatch("out_strb", 32'h0, 32'(out_strb));
        assert (!busy) else report_mismatch("busy", 32'h0, 32'(busy));
        assert (!ready_in) else report_mismatch("ready_in", 32'h0, 32'(ready_in));

        for (int i = 0; i < n_rows; i++) begin
            wait_idle();
            // the previous burst must have consumed exactly its own words
            assert (widx == words.size()) else report_mismatch("words consumed",
                32'(words.size()), 32'(widx));
            if (!bursts[i].reuse) begin
                words.delete();
                for (int w = 0; w < int'(bursts[i].words); w++) begin
                    words.push_back($urandom);
                end
            end
            push_expected(int'(bursts[i].offset), int'(bursts[i].words));
            widx = 0;
            stall_sel = bursts[i].stall;
            cmd_offset = bursts[i].offset;
            cmd_len = 8'(bursts[i].words - 9'd1);
            cmd_start = 1'b1;
            step();
            cmd_start = 1'b0;
        end

        wait_idle();
        for (int c = 0; c < 1000 && exp_q.size() > 0; c++) begin
            step();
        end
        assert (exp_q.size() == 0) else report_error("timed out waiting for the last output beats");
        assert (last_count == n_rows) else report_mismatch("out_last count", n_rows, last_count);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tests/burst_align_assertions.sv
// concurrent checks on the ports of the realignment path

module burst_align_assertions #(
    parameter int data_w = 32
) (
    input logic                clk,
    input logic                rst,
    input logic                ready_out,
    input logic                ready_in,
    input logic                busy,
    input logic                out_valid,
    input logic                out_last,
    input logic [data_w-1:0]   out_data,
    input logic [data_w/8-1:0] out_strb
);

    // a valid beat always carries at least one enabled lane
    strb_on_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (out_strb != '0))
        else $error("out_strb is zero on a valid output beat");

    // a stalled edge leaves the whole output beat untouched
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        !ready_out |=> ($stable(out_valid) && $stable(out_strb) && $stable(out_last) &&
                        (!out_valid || $stable(out_data))))
        else $error("output beat changed while ready_out was low");

    // words are only taken while a burst is running
    no_ready_when_idle: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !ready_in)
        else $error("ready_in is high while busy is low");

endmodule

bind burst_align_top burst_align_assertions #(.data_w(data_w)) i_assertions (.*);

// File: src/burst_align_top.sv
// write-data realignment path, control, shifter and strobe stages in a chain

module burst_align_top
    import burst_pkg::*;
#(
    parameter int data_w = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [MAX_OFFSET_W-1:0]  offset,
    input  logic [LEN_W-1:0]         len,
    input  logic [data_w-1:0]        data_in,
    input  logic                     ready_out,
    output logic                     ready_in,
    output logic                     busy,
    output logic [data_w-1:0]        out_data,
    output logic [data_w/BYTE_W-1:0] out_strb,
    output logic                     out_last,
    output logic                     out_valid
);

    beat_tag_t         tag_a;
    beat_tag_t         tag_b;
    logic [data_w-1:0] split_data;

    burst_ctrl #(
        .data_w (data_w)
    ) i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .offset    (offset),
        .len       (len),
        .ready_out (ready_out),
        .ready_in  (ready_in),
        .busy      (busy),
        .tag_a     (tag_a)
    );

    burst_split #(
        .data_w (data_w)
    ) i_split (
        .clk        (clk),
        .rst        (rst),
        .ready_out  (ready_out),
        .data_in    (data_in),
        .tag_a      (tag_a),
        .split_data (split_data),
        .tag_b      (tag_b)
    );

    // registered output beat, two advancing edges after its tag
    strobe_gen #(
        .data_w (data_w)
    ) i_strobe (
        .clk        (clk),
        .rst        (rst),
        .ready_out  (ready_out),
        .split_data (split_data),
        .tag_b      (tag_b),
        .out_data   (out_data),
        .out_strb   (out_strb),
        .out_last   (out_last),
        .out_valid  (out_valid)
    );

endmodule

// File: src/strobe_gen.sv
// output stage, derives the byte strobes from the beat tag and
// registers the beat that leaves the block

module strobe_gen
    import burst_pkg::*;
#(
    parameter int data_w = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ready_out,
    input  logic [data_w-1:0]          split_data,
    input  beat_tag_t                  tag_b,
    output logic [data_w-1:0]          out_data,
    output logic [data_w/BYTE_W-1:0]   out_strb,
    output logic                       out_last,
    output logic                       out_valid
);

    localparam int n_bytes = data_w / BYTE_W;
    localparam int off_w   = $clog2(n_bytes);

    logic [off_w-1:0]   off;
    logic [n_bytes-1:0] strb;

    assign off = tag_b.offset[off_w-1:0];

    // first beat: lanes at or above the offset
    // flush beat: lanes below the offset, i.e. the complement
    // anything else is a full word
    always_comb begin
        for (int j = 0; j < n_bytes; j++) begin
            if (tag_b.first) begin
                strb[j] = (j >= int'(off));
            end else if (tag_b.flush) begin
                strb[j] = (j < int'(off));
            end else begin
                strb[j] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_out) begin
            out_data <= split_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_strb  <= '0;
        end else if (ready_out) begin
            out_valid <= tag_b.valid;
            out_last  <= tag_b.valid && tag_b.last;
            // bubbles carry no enabled lanes
            out_strb  <= tag_b.valid ? strb : '0;
        end
    end

endmodule

// File: split/burst_split.sv
// byte shifter stage, moves each word up by the offset and keeps the
// bytes that fall off the top for the next beat

module burst_split
    import burst_pkg::*;
#(
    parameter int data_w = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ready_out,
    input  logic [data_w-1:0] data_in,
    input  beat_tag_t         tag_a,
    output logic [data_w-1:0] split_data,
    output beat_tag_t         tag_b
);

    localparam int n_bytes = data_w / BYTE_W;
    localparam int off_w   = $clog2(n_bytes);

    logic [off_w-1:0]  off;
    logic [data_w-1:0] leftover;
    logic [data_w-1:0] shifted;
    logic [data_w-1:0] next_leftover;

    assign off = tag_a.offset[off_w-1:0];

    always_comb begin
        int src;
        for (int j = 0; j < n_bytes; j++) begin
            if (j >= int'(off)) begin
                // upper lanes come from the current word, nothing on a flush beat
                src = j - int'(off);
                shifted[j*BYTE_W +: BYTE_W] = tag_a.flush ? '0 : data_in[src*BYTE_W +: BYTE_W];
                next_leftover[j*BYTE_W +: BYTE_W] = '0;
            end else begin
                // lower lanes are filled from what the previous word left over
                src = n_bytes - int'(off) + j;
                shifted[j*BYTE_W +: BYTE_W] = leftover[j*BYTE_W +: BYTE_W];
                next_leftover[j*BYTE_W +: BYTE_W] = data_in[src*BYTE_W +: BYTE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_out) begin
            split_data <= shifted;
            // only a consumed word refreshes the carried bytes
            if (tag_a.valid && !tag_a.flush) begin
                leftover <= next_leftover;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tag_b <= '0;
        end else if (ready_out) begin
            tag_b <= tag_a;
        end
    end

endmodule

// File: src/burst_ctrl.sv
// control stage of the realignment path
// accepts a burst command, counts the words and issues one tag per beat

module burst_ctrl
    import burst_pkg::*;
#(
    parameter int data_w = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [MAX_OFFSET_W-1:0] offset,
    input  logic [LEN_W-1:0]        len,
    input  logic                    ready_out,
    output logic                    ready_in,
    output logic                    busy,
    output beat_tag_t               tag_a
);

    // number of offset bits that are meaningful for this bus width
    localparam int off_w = $clog2(data_w / BYTE_W);

    // keeps only the offset bits that address a lane of this bus
    localparam logic [MAX_OFFSET_W-1:0] offset_mask = MAX_OFFSET_W'((1 << off_w) - 1);

    ctrl_state_e             state;
    logic [LEN_W-1:0]        words_left;
    logic [MAX_OFFSET_W-1:0] offset_q;
    logic                    first_pend;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= CTRL_IDLE;
            words_left <= '0;
            offset_q   <= '0;
            first_pend <= 1'b0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    // a command is taken even while the pipeline is stalled
                    // so that a single start pulse is never lost
                    if (start) begin
                        state      <= CTRL_BURST;
                        words_left <= len;
                        offset_q   <= offset & offset_mask;
                        first_pend <= 1'b1;
                    end
                end
                CTRL_BURST: begin
                    if (ready_out) begin
                        first_pend <= 1'b0;
                        if (words_left == '0) begin
                            // the last word still owes its top bytes when shifted
                            state <= (offset_q != '0) ? CTRL_FLUSH : CTRL_IDLE;
                        end else begin
                            words_left <= words_left - 1'b1;
                        end
                    end
                end
                CTRL_FLUSH: begin
                    if (ready_out) begin
                        state <= CTRL_IDLE;
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // a word is consumed at every edge where the burst state advances
    assign ready_in = (state == CTRL_BURST) && ready_out;
    assign busy     = (state != CTRL_IDLE);

    // tag of the beat issued in this cycle, split stage registers it
    always_comb begin
        tag_a.valid  = (state != CTRL_IDLE);
        tag_a.first  = first_pend;
        tag_a.flush  = (state == CTRL_FLUSH);
        // the flush beat closes the burst whenever one exists
        tag_a.last   = (state == CTRL_FLUSH) ||
                       ((state == CTRL_BURST) && (words_left == '0) && (offset_q == '0));
        tag_a.offset = offset_q;
    end

endmodule

// File: common/burst_pkg.sv
// shared types and widths for the write-data realignment path

package burst_pkg;

    // byte lane width, every bus width here is a whole number of bytes
    localparam int BYTE_W = 8;

    // offset field sized for the widest bus of 64 bits (8 byte lanes)
    // narrower buses leave the upper bits at zero
    localparam int MAX_OFFSET_W = 3;

    // burst length is encoded as number of words minus one
    localparam int LEN_W = 8;

    // control stage states
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_BURST = 2'd1,
        CTRL_FLUSH = 2'd2
    } ctrl_state_e;

    // per-beat tag that follows the data from stage to stage
    // a flush beat carries only the leftover bytes of the last word
    typedef struct packed {
        logic                    valid;
        logic                    first;
        logic                    last;
        logic                    flush;
        logic [MAX_OFFSET_W-1:0] offset;
    } beat_tag_t;

endpackage
